// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // basic widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned WORD_SEL_BITS = $clog2(LINE_WORDS);
  // byte offset within a line, two extra bits for the byte lane
  localparam int unsigned OFFSET_BITS = WORD_SEL_BITS + 2;

  // axi encodings used by the refill path
  localparam logic [2:0] AXI_SIZE_4B = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] word_t;

  // word 0 sits in the low bits of the line
  typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } fetch_rsp_t;

  typedef struct packed {
    addr_t pc;
    word_t inst;
  } inst_t;

  typedef struct packed {
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
  } axi_ar_t;

  typedef struct packed {
    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
  } axi_r_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    RESPOND
  } icache_state_e;

endpackage

// ==== hw/icache_line_store.sv ====
`timescale 1ns/1ps

module icache_line_store import fetch_pkg::*; #(
  parameter int unsigned NUM_LINES = 16
) (
  input  logic  clock,
  input  logic  reset,
  input  addr_t lookup_addr_i,
  output logic  hit_o,
  output word_t word_o,
  input  logic  write_i,
  input  addr_t write_addr_i,
  input  line_t write_line_i,
  input  logic  invalidate_i
);

  localparam int unsigned INDEX_BITS = $clog2(NUM_LINES);
  localparam int unsigned TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS;

  logic [TAG_BITS-1:0]      tag_mem [NUM_LINES];
  line_t                    data_mem [NUM_LINES];
  logic [NUM_LINES-1:0]     valid_q;

  logic [TAG_BITS-1:0]      lookup_tag;
  logic [INDEX_BITS-1:0]    lookup_index;
  logic [WORD_SEL_BITS-1:0] lookup_word;
  logic [TAG_BITS-1:0]      write_tag;
  logic [INDEX_BITS-1:0]    write_index;

  logic                     hit_q;
  word_t                    word_q;

  // tag | index | offset
  assign lookup_tag = lookup_addr_i[XLEN-1 -: TAG_BITS];
  assign lookup_index = lookup_addr_i[OFFSET_BITS +: INDEX_BITS];
  assign lookup_word = lookup_addr_i[2 +: WORD_SEL_BITS];
  assign write_tag = write_addr_i[XLEN-1 -: TAG_BITS];
  assign write_index = write_addr_i[OFFSET_BITS +: INDEX_BITS];

  // flush wins over a fill in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write_i) begin
      tag_mem[write_index] <= write_tag;
      data_mem[write_index] <= write_line_i;
    end
  end

  // result shows up one cycle after the address
  always_ff @(posedge clock) begin
    if (reset) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    end
  end

  always_ff @(posedge clock) begin
    word_q <= data_mem[lookup_index][lookup_word];
  end

  assign hit_o = hit_q;
  assign word_o = word_q;

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/1ps

module icache import fetch_pkg::*; #(
  parameter int unsigned NUM_LINES = 16
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       flush_i,
  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  input  logic       rsp_ready_i,
  output logic       fill_valid_o,
  output addr_t      fill_addr_o,
  input  logic       fill_done_i,
  input  line_t      fill_line_i,
  output word_t      hit_count_o,
  output word_t      miss_count_o
);

  icache_state_e            state_q;
  icache_state_e            state_d;
  addr_t                    req_addr_q;
  word_t                    rsp_data_q;
  logic                     flush_pending_q;
  word_t                    hit_count_q;
  word_t                    miss_count_q;

  logic                     req_fire;
  logic                     store_hit;
  word_t                    store_word;
  logic                     store_write;
  logic                     store_invalidate;
  logic [WORD_SEL_BITS-1:0] req_word;

  // no new work while a flush waits, so the FSM drains back to IDLE
  assign req_ready_o = !flush_i && !flush_pending_q &&
                       ((state_q == IDLE) || ((state_q == RESPOND) && rsp_ready_i));
  assign req_fire = req_valid_i && req_ready_o;

  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_o.addr = req_addr_q;
  assign rsp_o.data = rsp_data_q;

  assign fill_valid_o = (state_q == REFILL);
  assign fill_addr_o = {req_addr_q[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  assign req_word = req_addr_q[2 +: WORD_SEL_BITS];
  // a refill that saw a flush still answers but leaves the arrays alone
  assign store_write = (state_q == REFILL) && fill_done_i && !flush_pending_q && !flush_i;
  assign store_invalidate = (state_q == IDLE) && (flush_i || flush_pending_q);

  icache_line_store #(
    .NUM_LINES(NUM_LINES)
  ) line_store_i (
    .clock        (clock),
    .reset        (reset),
    .lookup_addr_i(req_i.addr),
    .hit_o        (store_hit),
    .word_o       (store_word),
    .write_i      (store_write),
    .write_addr_i (req_addr_q),
    .write_line_i (fill_line_i),
    .invalidate_i (store_invalidate)
  );

  // back-to-back hits go RESPOND -> LOOKUP without passing IDLE
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_fire) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = store_hit ? RESPOND : REFILL;
      end
      REFILL: begin
        if (fill_done_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (req_fire) begin
          state_d = LOOKUP;
        end else if (rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      flush_pending_q <= 1'b0;
      hit_count_q <= '0;
      miss_count_q <= '0;
    end else begin
      state_q <= state_d;
      if (store_invalidate) begin
        flush_pending_q <= 1'b0;
      end else if (flush_i) begin
        flush_pending_q <= 1'b1;
      end
      // one count per accepted request, decided in LOOKUP
      if (state_q == LOOKUP) begin
        if (store_hit) begin
          hit_count_q <= hit_count_q + 1'b1;
        end else begin
          miss_count_q <= miss_count_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire) begin
      req_addr_q <= req_i.addr;
    end
    if ((state_q == LOOKUP) && store_hit) begin
      rsp_data_q <= store_word;
    end else if ((state_q == REFILL) && fill_done_i) begin
      rsp_data_q <= fill_line_i[req_word];
    end
  end

  assign hit_count_o = hit_count_q;
  assign miss_count_o = miss_count_q;

endmodule

// ==== hw/axi_line_reader.sv ====
`timescale 1ns/1ps

module axi_line_reader import fetch_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    fill_valid_i,
  input  addr_t   fill_addr_i,
  output logic    fill_done_o,
  output line_t   fill_line_o,
  output logic    axi_ar_valid_o,
  output axi_ar_t axi_ar_o,
  input  logic    axi_ar_ready_i,
  input  logic    axi_r_valid_i,
  input  axi_r_t  axi_r_i,
  output logic    axi_r_ready_o,
  output logic    bus_error_o
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_DONE
  } reader_state_e;

  reader_state_e            state_q;
  addr_t                    addr_q;
  line_t                    line_q;
  logic [WORD_SEL_BITS-1:0] beat_q;
  logic                     error_q;
  logic                     beat_fire;

  assign beat_fire = (state_q == RD_DATA) && axi_r_valid_i;

  assign axi_ar_valid_o = (state_q == RD_ADDR);
  assign axi_ar_o.araddr = addr_q;
  assign axi_ar_o.arlen = 8'(LINE_WORDS - 1);
  assign axi_ar_o.arsize = AXI_SIZE_4B;
  assign axi_ar_o.arburst = AXI_BURST_INCR;
  // rready stays up for the whole burst
  assign axi_r_ready_o = (state_q == RD_DATA);

  assign fill_done_o = (state_q == RD_DONE);
  assign fill_line_o = line_q;
  assign bus_error_o = error_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= RD_IDLE;
      beat_q <= '0;
      error_q <= 1'b0;
    end else begin
      unique case (state_q)
        RD_IDLE: begin
          if (fill_valid_i) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (axi_ar_ready_i) begin
            state_q <= RD_DATA;
            beat_q <= '0;
          end
        end
        RD_DATA: begin
          if (axi_r_valid_i) begin
            beat_q <= beat_q + 1'b1;
            if (axi_r_i.rlast) begin
              state_q <= RD_DONE;
            end
          end
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
      // sticky until reset, nothing retries
      if (beat_fire && (axi_r_i.rresp != AXI_RESP_OKAY)) begin
        error_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((state_q == RD_IDLE) && fill_valid_i) begin
      addr_q <= fill_addr_i;
    end
    if (beat_fire) begin
      line_q[beat_q] <= axi_r_i.rdata;
    end
  end

endmodule

// ==== hw/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h0000_0000
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       redirect_i,
  input  addr_t      redirect_pc_i,
  output logic       req_valid_o,
  output fetch_req_t req_o,
  input  logic       req_ready_i,
  input  logic       rsp_valid_i,
  input  fetch_rsp_t rsp_i,
  output logic       rsp_ready_o,
  output logic       inst_valid_o,
  output inst_t      inst_o,
  input  logic       inst_ready_i
);

  addr_t pc_q;
  logic  started_q;
  logic  stale_q;
  logic  buf_valid_q;
  inst_t buf_q;

  logic  req_fire;
  logic  rsp_fire;
  logic  rsp_drop;

  assign req_valid_o = started_q;
  assign req_o.addr = pc_q;
  assign req_fire = req_valid_o && req_ready_i;

  // anything answered during a redirect belongs to the old path
  assign rsp_drop = stale_q || redirect_i;
  assign rsp_ready_o = rsp_drop || !buf_valid_q || inst_ready_i;
  assign rsp_fire = rsp_valid_i && rsp_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (req_fire) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // stale marks the request now held by the cache
  always_ff @(posedge clock) begin
    if (reset) begin
      stale_q <= 1'b0;
    end else if (req_fire) begin
      stale_q <= redirect_i;
    end else if (rsp_fire) begin
      stale_q <= 1'b0;
    end else if (redirect_i) begin
      stale_q <= 1'b1;
    end
  end

  // one-entry output buffer
  always_ff @(posedge clock) begin
    if (reset) begin
      buf_valid_q <= 1'b0;
    end else if (redirect_i) begin
      buf_valid_q <= 1'b0;
    end else if (rsp_fire && !stale_q) begin
      buf_valid_q <= 1'b1;
    end else if (inst_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rsp_fire && !rsp_drop) begin
      buf_q.pc <= rsp_i.addr;
      buf_q.inst <= rsp_i.data;
    end
  end

  assign inst_valid_o = buf_valid_q;
  assign inst_o = buf_q;

endmodule

// ==== hw/fetch_subsystem.sv ====
`timescale 1ns/1ps

module fetch_subsystem import fetch_pkg::*; #(
  parameter int unsigned NUM_LINES = 16,
  parameter addr_t       RESET_PC = 32'h8000_0000
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    flush_i,
  input  logic    redirect_i,
  input  addr_t   redirect_pc_i,
  output logic    inst_valid_o,
  output inst_t   inst_o,
  input  logic    inst_ready_i,
  output logic    axi_ar_valid_o,
  output axi_ar_t axi_ar_o,
  input  logic    axi_ar_ready_i,
  input  logic    axi_r_valid_i,
  input  axi_r_t  axi_r_i,
  output logic    axi_r_ready_o,
  output word_t   hit_count_o,
  output word_t   miss_count_o,
  output logic    bus_error_o
);

  // sequencer to cache
  logic       req_valid;
  fetch_req_t req;
  logic       req_ready;
  logic       rsp_valid;
  fetch_rsp_t rsp;
  logic       rsp_ready;

  // cache to line reader
  logic       fill_valid;
  addr_t      fill_addr;
  logic       fill_done;
  line_t      fill_line;

  fetch_sequencer #(
    .RESET_PC(RESET_PC)
  ) sequencer_i (
    .clock        (clock),
    .reset        (reset),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .req_valid_o  (req_valid),
    .req_o        (req),
    .req_ready_i  (req_ready),
    .rsp_valid_i  (rsp_valid),
    .rsp_i        (rsp),
    .rsp_ready_o  (rsp_ready),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_ready_i (inst_ready_i)
  );

  icache #(
    .NUM_LINES(NUM_LINES)
  ) icache_i (
    .clock       (clock),
    .reset       (reset),
    .flush_i     (flush_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .fill_valid_o(fill_valid),
    .fill_addr_o (fill_addr),
    .fill_done_i (fill_done),
    .fill_line_i (fill_line),
    .hit_count_o (hit_count_o),
    .miss_count_o(miss_count_o)
  );

  axi_line_reader line_reader_i (
    .clock         (clock),
    .reset         (reset),
    .fill_valid_i  (fill_valid),
    .fill_addr_i   (fill_addr),
    .fill_done_o   (fill_done),
    .fill_line_o   (fill_line),
    .axi_ar_valid_o(axi_ar_valid_o),
    .axi_ar_o      (axi_ar_o),
    .axi_ar_ready_i(axi_ar_ready_i),
    .axi_r_valid_i (axi_r_valid_i),
    .axi_r_i       (axi_r_i),
    .axi_r_ready_o (axi_r_ready_o),
    .bus_error_o   (bus_error_o)
  );

endmodule

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import fetch_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    ar_valid_i,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output logic    r_valid_o,
  output axi_r_t  r_o,
  input  logic    r_ready_i
);

  localparam word_t DATA_XOR = 32'hc0de_0000;

  logic        ar_ready_q = 1'b0;
  logic        r_valid_q = 1'b0;
  logic        busy_q = 1'b0;
  addr_t       addr_q = '0;
  int unsigned beats_left_q = 0;
  int unsigned stall_q = 0;

  // one burst at a time, each handshake preceded by 0 to 3 idle cycles
  always @(posedge clock) begin
    if (reset) begin
      ar_ready_q <= 1'b0;
      r_valid_q <= 1'b0;
      busy_q <= 1'b0;
      beats_left_q <= 0;
      stall_q <= 0;
    end else if (!busy_q) begin
      if (ar_valid_i && ar_ready_q) begin
        ar_ready_q <= 1'b0;
        busy_q <= 1'b1;
        addr_q <= ar_i.araddr;
        beats_left_q <= ar_i.arlen + 1;
        stall_q <= $urandom_range(0, 3);
      end else if (ar_valid_i) begin
        if (stall_q == 0) begin
          ar_ready_q <= 1'b1;
        end else begin
          stall_q <= stall_q - 1;
        end
      end
    end else if (r_valid_q && r_ready_i) begin
      r_valid_q <= 1'b0;
      addr_q <= addr_q + 32'd4;
      beats_left_q <= beats_left_q - 1;
      stall_q <= $urandom_range(0, 3);
      if (beats_left_q == 1) begin
        busy_q <= 1'b0;
      end
    end else if (!r_valid_q) begin
      if (stall_q == 0) begin
        r_valid_q <= 1'b1;
      end else begin
        stall_q <= stall_q - 1;
      end
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o = r_valid_q;
  // word contents follow from the byte address alone
  assign r_o.rdata = addr_q ^ DATA_XOR;
  assign r_o.rresp = AXI_RESP_OKAY;
  assign r_o.rlast = (beats_left_q == 1);

endmodule

// ==== dv/tb_fetch_subsystem.sv ====
`timescale 1ns/1ps

module tb_fetch_subsystem import fetch_pkg::*; ();

  localparam addr_t       RESET_PC = 32'h8000_0000;
  localparam int unsigned NUM_LINES = 16;
  localparam word_t       INST_XOR = 32'hc0de_0000;
  localparam int unsigned SEED = 32'h1ffacc5c;
  localparam addr_t       LOOP_PC = 32'h8000_0400;
  // stimulus phases below, each budgeted by the watchdog
  localparam int unsigned NUM_STEPS = 10;
  localparam int unsigned CYCLES_PER_STEP = 200;

  logic        clock;
  logic        reset;
  logic        flush_i;
  logic        redirect_i;
  addr_t       redirect_pc_i;
  logic        inst_valid_o;
  inst_t       inst_o;
  logic        inst_ready_i;
  logic        axi_ar_valid;
  axi_ar_t     axi_ar;
  logic        axi_ar_ready;
  logic        axi_r_valid;
  axi_r_t      axi_r;
  logic        axi_r_ready;
  word_t       hit_count;
  word_t       miss_count;
  logic        bus_error;

  int unsigned errors;
  int unsigned delivered;
  int unsigned req_accepted_q;
  int unsigned req_accepted_d;
  addr_t       expected_pc;
  word_t       miss_base;
  string       test_name;
  logic        inst_fire;
  logic        req_fire;
  logic        in_burst;

  fetch_subsystem #(
    .NUM_LINES(NUM_LINES),
    .RESET_PC (RESET_PC)
  ) fetch_subsystem_i (
    .clock         (clock),
    .reset         (reset),
    .flush_i       (flush_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_ready_i  (inst_ready_i),
    .axi_ar_valid_o(axi_ar_valid),
    .axi_ar_o      (axi_ar),
    .axi_ar_ready_i(axi_ar_ready),
    .axi_r_valid_i (axi_r_valid),
    .axi_r_i       (axi_r),
    .axi_r_ready_o (axi_r_ready),
    .hit_count_o   (hit_count),
    .miss_count_o  (miss_count),
    .bus_error_o   (bus_error)
  );

  axi_mem_model mem_model_i (
    .clock     (clock),
    .reset     (reset),
    .ar_valid_i(axi_ar_valid),
    .ar_i      (axi_ar),
    .ar_ready_o(axi_ar_ready),
    .r_valid_o (axi_r_valid),
    .r_o       (axi_r),
    .r_ready_i (axi_r_ready)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  assign inst_fire = inst_valid_o && inst_ready_i;
  // requests seen on the internal sequencer to cache handshake
  assign req_fire = fetch_subsystem_i.req_valid && fetch_subsystem_i.req_ready;

  // scoreboard: expected pc follows sequential order and redirects
  always @(posedge clock) begin
    if (reset) begin
      expected_pc <= RESET_PC;
      delivered <= 0;
      req_accepted_q <= 0;
      req_accepted_d <= 0;
    end else begin
      if (inst_fire) begin
        delivered <= delivered + 1;
      end
      if (redirect_i) begin
        expected_pc <= redirect_pc_i;
      end else if (inst_fire) begin
        expected_pc <= expected_pc + 32'd4;
      end
      if (req_fire) begin
        req_accepted_q <= req_accepted_q + 1;
      end
      // counters settle one cycle after acceptance
      req_accepted_d <= req_accepted_q;
    end
  end

  // a burst runs from the address handshake to the beat with rlast
  always @(posedge clock) begin
    if (reset) begin
      in_burst <= 1'b0;
    end else if (axi_ar_valid && axi_ar_ready) begin
      in_burst <= 1'b1;
    end else if (axi_r_valid && axi_r_ready && axi_r.rlast) begin
      in_burst <= 1'b0;
    end
  end

  pc_order: assert property (@(posedge clock) disable iff (reset)
      inst_fire |-> (inst_o.pc == expected_pc))
    else begin
      errors = errors + 1;
      $display("[FAIL] %s pc: expected %h actual %h",
               test_name, $sampled(expected_pc), $sampled(inst_o.pc));
    end

  inst_data: assert property (@(posedge clock) disable iff (reset)
      inst_fire |-> (inst_o.inst == (expected_pc ^ INST_XOR)))
    else begin
      errors = errors + 1;
      $display("[FAIL] %s inst: expected %h actual %h",
               test_name, $sampled(expected_pc) ^ INST_XOR, $sampled(inst_o.inst));
    end

  output_hold: assert property (@(posedge clock) disable iff (reset)
      (inst_valid_o && !inst_ready_i && !redirect_i) |=> (inst_valid_o && $stable(inst_o)))
    else begin
      errors = errors + 1;
      $display("%s: instruction output dropped or changed while stalled", test_name);
    end

  count_sum: assert property (@(posedge clock) disable iff (reset)
      (hit_count + miss_count) == req_accepted_d)
    else begin
      errors = errors + 1;
      $display("[FAIL] %s hits plus misses: expected %0d actual %0d",
               test_name, $sampled(req_accepted_d), $sampled(hit_count + miss_count));
    end

  ar_len: assert property (@(posedge clock) disable iff (reset)
      axi_ar_valid |-> (axi_ar.arlen == 8'd3))
    else begin
      errors = errors + 1;
      $display("[FAIL] %s arlen: expected %0d actual %0d", test_name, 3, $sampled(axi_ar.arlen));
    end

  ar_kind: assert property (@(posedge clock) disable iff (reset)
      axi_ar_valid |-> ((axi_ar.arburst == 2'b01) && (axi_ar.arsize == 3'b010)))
    else begin
      errors = errors + 1;
      $display("[FAIL] %s burst/size: expected 1/2 actual %0d/%0d",
               test_name, $sampled(axi_ar.arburst), $sampled(axi_ar.arsize));
    end

  ar_align: assert property (@(posedge clock) disable iff (reset)
      axi_ar_valid |-> (axi_ar.araddr[3:0] == 4'h0))
    else begin
      errors = errors + 1;
      $display("%s: read burst address %h is not line aligned", test_name, $sampled(axi_ar.araddr));
    end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
      (axi_ar_valid && !axi_ar_ready) |=> (axi_ar_valid && $stable(axi_ar)))
    else begin
      errors = errors + 1;
      $display("%s: read address withdrawn or changed before handshake", test_name);
    end

  r_ready_burst: assert property (@(posedge clock) disable iff (reset)
      axi_r_ready == in_burst)
    else begin
      errors = errors + 1;
      $display("[FAIL] %s rready: expected %0d actual %0d",
               test_name, $sampled(in_burst), $sampled(axi_r_ready));
    end

  no_bus_error: assert property (@(posedge clock) disable iff (reset) !bus_error)
    else begin
      errors = errors + 1;
      $display("%s: bus error flag raised", test_name);
    end

  task automatic take_instructions(input int unsigned count, input logic random_ready);
    int unsigned target;
    target = delivered + count;
    while (delivered < target) begin
      if (random_ready) begin
        inst_ready_i = 1'($urandom_range(0, 1));
      end else begin
        inst_ready_i = 1'b1;
      end
      @(posedge clock);
      #1;
    end
  endtask

  // stall the consumer until buffer and cache both hold a response
  task automatic wait_quiet();
    inst_ready_i = 1'b0;
    while (!(inst_valid_o && fetch_subsystem_i.rsp_valid)) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic redirect_to(input addr_t pc);
    redirect_pc_i = pc;
    redirect_i = 1'b1;
    @(posedge clock);
    #1;
    redirect_i = 1'b0;
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(posedge clock);
    #1;
    flush_i = 1'b0;
  endtask

  // 8 instructions span the lines at LOOP_PC and LOOP_PC + 16
  task automatic run_loop_pass();
    redirect_to(LOOP_PC);
    take_instructions(8, 1'b0);
    wait_quiet();
  endtask

  task automatic check_misses(input word_t expected);
    assert (miss_count == expected)
      else begin
        errors = errors + 1;
        $display("[FAIL] %s miss count: expected %0d actual %0d", test_name, expected, miss_count);
      end
  endtask

  initial begin
    errors = 0;
    test_name = "reset";
    reset = 1'b1;
    flush_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i = 1'b0;
    void'($urandom(SEED));
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    test_name = "sequential";
    take_instructions(40, 1'b0);
    wait_quiet();

    test_name = "redirect";
    redirect_to(32'h8000_0200);
    take_instructions(6, 1'b0);
    // lands while instructions are still flowing
    redirect_to(32'h8000_0300);
    take_instructions(10, 1'b0);
    wait_quiet();

    test_name = "back_pressure";
    take_instructions(40, 1'b1);
    wait_quiet();

    test_name = "hit_reuse";
    run_loop_pass();
    miss_base = miss_count;
    repeat (3) run_loop_pass();
    check_misses(miss_base);

    // three lines were cached, each must refill once
    test_name = "flush";
    miss_base = miss_count;
    pulse_flush();
    run_loop_pass();
    check_misses(miss_base + 32'd3);

    // flush arrives while 0x800 is looked up, so its line is refetched
    test_name = "flush_during_refill";
    miss_base = miss_count;
    redirect_to(32'h8000_0800);
    repeat (2) @(posedge clock);
    #1;
    pulse_flush();
    take_instructions(6, 1'b0);
    wait_quiet();
    check_misses(miss_base + 32'd3);

    $display("summary: %0d errors, %0d instructions checked", errors, delivered);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_STEPS * CYCLES_PER_STEP) @(posedge clock);
    $display("timeout: run still busy after %0d cycles", NUM_STEPS * CYCLES_PER_STEP);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== compile.f ====
hw/fetch_pkg.sv
hw/icache_line_store.sv
hw/icache.sv
hw/axi_line_reader.sv
hw/fetch_sequencer.sv
hw/fetch_subsystem.sv
dv/axi_mem_model.sv
dv/tb_fetch_subsystem.sv
